// File: Makefile
# Verilator build and run for ooo_tracker

VERILATOR ?= verilator
TOP       ?= ooo_tracker_tb
FILELIST  ?= ooo_tracker.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN  = $(OBJ_DIR)/V$(TOP)
FAIL_MSG = FAIL: see errors above
PASS_MSG = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without passing"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/completion_matcher.sv
// Completion lookup and result sequencer
`timescale 1ns/1ps
`default_nettype none

module completion_matcher import ooo_tracker_pkg::*; (
  input  wire logic        clock,
  input  wire logic        resetn,
  // Four-phase completion channel
  input  wire logic        completion_req,
  input  wire completion_t completion_data,
  output logic             completion_ack,
  // Four-phase result channel
  output logic             result_req,
  output result_t          result_data,
  input  wire logic        result_ack,
  // Buffer lookup side
  output logic             read_enable,
  output logic             read_clear,
  output tag_t             read_index,
  input  wire request_t    read_data,
  input  wire logic        read_error
);

  typedef enum logic [1:0] {
    MATCH_IDLE,
    MATCH_RESULT_HIGH,
    MATCH_RESULT_LOW,
    MATCH_COMP_ACK
  } match_state_t;

  match_state_t state;

  // Lookup and free in the cycle the completion is seen
  assign read_enable    = (state == MATCH_IDLE) && completion_req;
  assign read_clear     = read_enable;
  assign read_index     = completion_data.tag;

  assign result_req     = (state == MATCH_RESULT_HIGH);
  assign completion_ack = (state == MATCH_COMP_ACK);

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      state <= MATCH_IDLE;
    end else begin
      case (state)
        MATCH_IDLE:        if (completion_req) state <= MATCH_RESULT_HIGH;
        // Drop result_req once downstream acks
        MATCH_RESULT_HIGH: if (result_ack) state <= MATCH_RESULT_LOW;
        // Completion ack waits for the result ack to fall
        MATCH_RESULT_LOW:  if (!result_ack) state <= MATCH_COMP_ACK;
        MATCH_COMP_ACK:    if (!completion_req) state <= MATCH_IDLE;
        default:           state <= MATCH_IDLE;
      endcase
    end
  end

  // Result held stable through the result handshake
  always_ff @(posedge clock) begin
    if (read_enable) begin
      result_data.tag      <= completion_data.tag;
      // No stored request behind an unknown tag
      result_data.request  <= read_error ? '0 : read_data;
      result_data.response <= completion_data.response;
      result_data.error    <= read_error;
    end
  end

endmodule

`default_nettype wire

// File: design/first_free_encoder.sv
// Lowest free slot encoder
`timescale 1ns/1ps
`default_nettype none

module first_free_encoder #(
  parameter int SLOTS = 8
) (
  input  wire logic [SLOTS-1:0]         valid,
  output logic      [$clog2(SLOTS)-1:0] index,
  output logic                          none_free
);

  localparam int INDEX_W = $clog2(SLOTS);

  // Free mask and its lowest set bit
  logic [SLOTS-1:0] free;
  logic [SLOTS-1:0] lowest;

  always_comb begin
    free   = ~valid;
    // Two's complement trick keeps only the lowest set bit
    lowest = free & (~free + SLOTS'(1));
    // One-hot to binary, zero when nothing is free
    index  = '0;
    for (int slot = 0; slot < SLOTS; slot++) begin
      if (lowest[slot]) begin
        index = index | INDEX_W'(slot);
      end
    end
    none_free = ~|free;
  end

endmodule

`default_nettype wire

// File: design/ooo_tracker_pkg.sv
// Tracker channel types
`default_nettype none

`include "ooo_tracker_settings.svh"

package ooo_tracker_pkg;

  // Slot index, also the tag handed back to the requester
  typedef logic [$clog2(`OOO_SLOTS)-1:0] tag_t;

  // Request as seen on the request channel and stored in a slot
  typedef struct packed {
    logic [`OOO_ADDR_W-1:0] addr;
    logic [`OOO_DATA_W-1:0] wdata;
  } request_t;

  // Completion coming back out of order
  typedef struct packed {
    tag_t                   tag;
    logic [`OOO_RESP_W-1:0] response;
  } completion_t;

  // Stored request joined with its response
  // error set when the tag was not outstanding
  typedef struct packed {
    tag_t                   tag;
    request_t               request;
    logic [`OOO_RESP_W-1:0] response;
    logic                   error;
  } result_t;

endpackage

`default_nettype wire

// File: design/ooo_tracker_settings.svh
// Tracker size settings
`ifndef OOO_TRACKER_SETTINGS_SVH
`define OOO_TRACKER_SETTINGS_SVH

// Number of slots in the out-of-order buffer
`define OOO_SLOTS 8

// Request address width
`define OOO_ADDR_W 16

// Request write data width
`define OOO_DATA_W 16

// Completion response width
`define OOO_RESP_W 16

`endif

// File: design/ooo_tracker_top.sv
// Outstanding transaction tracker
`timescale 1ns/1ps
`default_nettype none

`include "ooo_tracker_settings.svh"

module ooo_tracker_top import ooo_tracker_pkg::*; (
  input  wire logic        clock,
  input  wire logic        resetn,
  // Request channel
  input  wire logic        request_req,
  input  wire request_t    request_data,
  output logic             request_ack,
  output tag_t             request_tag,
  // Completion channel
  input  wire logic        completion_req,
  input  wire completion_t completion_data,
  output logic             completion_ack,
  // Result channel
  output logic             result_req,
  output result_t          result_data,
  input  wire logic        result_ack,
  // Buffer status
  output logic             full,
  output logic             empty
);

  // Allocate side between issuer and buffer
  logic     write_enable;
  request_t write_data;
  tag_t     write_index;

  // Lookup side between matcher and buffer
  logic     read_enable;
  logic     read_clear;
  tag_t     read_index;
  request_t read_data;
  logic     read_error;

  request_issuer issuer (
    .clock        ( clock        ),
    .resetn       ( resetn       ),
    .request_req  ( request_req  ),
    .request_data ( request_data ),
    .request_ack  ( request_ack  ),
    .request_tag  ( request_tag  ),
    .full         ( full         ),
    .write_index  ( write_index  ),
    .write_enable ( write_enable ),
    .write_data   ( write_data   )
  );

  completion_matcher matcher (
    .clock           ( clock           ),
    .resetn          ( resetn          ),
    .completion_req  ( completion_req  ),
    .completion_data ( completion_data ),
    .completion_ack  ( completion_ack  ),
    .result_req      ( result_req      ),
    .result_data     ( result_data     ),
    .result_ack      ( result_ack      ),
    .read_enable     ( read_enable     ),
    .read_clear      ( read_clear      ),
    .read_index      ( read_index      ),
    .read_data       ( read_data       ),
    .read_error      ( read_error      )
  );

  // Slots hold the original request
  out_of_order_buffer #(
    .payload_t    ( request_t    ),
    .DEPTH        ( `OOO_SLOTS   )
  ) slot_buffer (
    .clock        ( clock        ),
    .resetn       ( resetn       ),
    .full         ( full         ),
    .empty        ( empty        ),
    .write_enable ( write_enable ),
    .write_data   ( write_data   ),
    .write_index  ( write_index  ),
    .read_enable  ( read_enable  ),
    .read_clear   ( read_clear   ),
    .read_index   ( read_index   ),
    .read_data    ( read_data    ),
    .read_error   ( read_error   )
  );

endmodule

`default_nettype wire

// File: design/out_of_order_buffer.sv
// Out-of-order slot buffer
`timescale 1ns/1ps
`default_nettype none

`include "ooo_tracker_settings.svh"

module out_of_order_buffer import ooo_tracker_pkg::*; #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = `OOO_SLOTS
) (
  input  wire logic     clock,
  input  wire logic     resetn,
  output logic          full,
  output logic          empty,
  // Allocate side
  input  wire logic     write_enable,
  input  wire payload_t write_data,
  output tag_t          write_index,
  // Lookup side
  input  wire logic     read_enable,
  input  wire logic     read_clear,
  input  wire tag_t     read_index,
  output payload_t      read_data,
  output logic          read_error
);

  // Slot storage and occupancy
  payload_t         slots [DEPTH];
  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] valid_next;

  // First free slot from the encoder
  tag_t first_free;
  logic none_free;
  logic write_accept;

  first_free_encoder #(
    .SLOTS     ( DEPTH      )
  ) free_slot_encoder (
    .valid     ( valid      ),
    .index     ( first_free ),
    .none_free ( none_free  )
  );

  // Index is known in the same cycle as the write
  assign write_index  = first_free;
  // A write with no free slot is dropped
  assign write_accept = write_enable && !none_free;

  // Next occupancy
  always_comb begin
    valid_next = valid;
    if (write_accept) begin
      valid_next[first_free] = 1'b1;
    end
    // Clearing an empty slot leaves state alone
    if (read_enable && read_clear && valid[read_index]) begin
      valid_next[read_index] = 1'b0;
    end
  end

  // Combinational lookup
  assign read_data  = slots[read_index];
  assign read_error = read_enable && !valid[read_index];

  // Payload storage
  always_ff @(posedge clock) begin
    if (write_accept) begin
      slots[first_free] <= write_data;
    end
  end

  // Occupancy and flags
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      valid <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end else begin
      valid <= valid_next;
      // Flags follow the occupancy just written
      full  <= &valid_next;
      empty <= ~|valid_next;
    end
  end

endmodule

`default_nettype wire

// File: design/request_issuer.sv
// Request channel responder
`timescale 1ns/1ps
`default_nettype none

module request_issuer import ooo_tracker_pkg::*; (
  input  wire logic     clock,
  input  wire logic     resetn,
  // Four-phase request channel
  input  wire logic     request_req,
  input  wire request_t request_data,
  output logic          request_ack,
  output tag_t          request_tag,
  // Buffer allocate side
  input  wire logic     full,
  input  wire tag_t     write_index,
  output logic          write_enable,
  output request_t      write_data
);

  typedef enum logic {
    ISSUE_IDLE,
    ISSUE_ACK
  } issue_state_t;

  issue_state_t state;

  // Allocate once per handshake, held off while full
  assign write_enable = (state == ISSUE_IDLE) && request_req && !full;
  assign write_data   = request_data;

  // Ack is the state itself
  assign request_ack  = (state == ISSUE_ACK);

  // Handshake sequencing
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      state <= ISSUE_IDLE;
    end else begin
      case (state)
        ISSUE_IDLE: begin
          if (write_enable) begin
            state <= ISSUE_ACK;
          end
        end
        ISSUE_ACK: begin
          // Release once the requester drops req
          if (!request_req) begin
            state <= ISSUE_IDLE;
          end
        end
        default: state <= ISSUE_IDLE;
      endcase
    end
  end

  // Slot number goes back as the tag
  // only read while ack is high
  always_ff @(posedge clock) begin
    if (write_enable) begin
      request_tag <= write_index;
    end
  end

endmodule

`default_nettype wire

// File: ooo_tracker.f
+incdir+design
design/ooo_tracker_pkg.sv
design/first_free_encoder.sv
design/out_of_order_buffer.sv
design/request_issuer.sv
design/completion_matcher.sv
design/ooo_tracker_top.sv
testbench/ooo_tracker_sva.sv
testbench/ooo_tracker_tb.sv

// File: testbench/ooo_tracker_sva.sv
// Tracker protocol assertions
`timescale 1ns/1ps
`default_nettype none

module ooo_tracker_sva import ooo_tracker_pkg::*; (
  input wire logic    clock,
  input wire logic    resetn,
  input wire logic    request_req,
  input wire logic    request_ack,
  input wire logic    completion_req,
  input wire logic    completion_ack,
  input wire logic    result_req,
  input wire logic    result_ack,
  input wire result_t result_data,
  input wire logic    full,
  input wire logic    empty
);

  // Registered acks answer the req seen on the edge before
  request_ack_rise: assert property (
    @(posedge clock) disable iff (!resetn) $rose(request_ack) |-> $past(request_req)
  ) else $error("request_ack rose without request_req");

  completion_ack_rise: assert property (
    @(posedge clock) disable iff (!resetn) $rose(completion_ack) |-> $past(completion_req)
  ) else $error("completion_ack rose without completion_req");

  // Downstream ack must find result_req still up
  result_ack_rise: assert property (
    @(posedge clock) disable iff (!resetn) $rose(result_ack) |-> result_req
  ) else $error("result_ack rose without result_req");

  // Result payload held through the result handshake
  result_stable: assert property (
    @(posedge clock) disable iff (!resetn)
      result_req && $past(result_req) |-> $stable(result_data)
  ) else $error("result_data changed while result_req was high");

  flags_exclusive: assert property (
    @(posedge clock) disable iff (!resetn) !(full && empty)
  ) else $error("full and empty both high");

endmodule

bind ooo_tracker_top ooo_tracker_sva protocol_checks (
  .clock          ( clock          ),
  .resetn         ( resetn         ),
  .request_req    ( request_req    ),
  .request_ack    ( request_ack    ),
  .completion_req ( completion_req ),
  .completion_ack ( completion_ack ),
  .result_req     ( result_req     ),
  .result_ack     ( result_ack     ),
  .result_data    ( result_data    ),
  .full           ( full           ),
  .empty          ( empty          )
);

`default_nettype wire

// File: testbench/ooo_tracker_tb.sv
// Tracker testbench
`timescale 1ns/1ps
`default_nettype none

`include "ooo_tracker_settings.svh"

module ooo_tracker_tb import ooo_tracker_pkg::*; ();

  localparam int SLOTS          = `OOO_SLOTS;
  localparam int MIX_OPS        = 300;
  // Directed transactions on top of the random mix
  localparam int TRANS_COUNT    = MIX_OPS + 40;
  localparam int TIMEOUT_CYCLES = 200 * TRANS_COUNT;

  logic        clock;
  logic        resetn;
  logic        request_req;
  request_t    request_data;
  logic        request_ack;
  tag_t        request_tag;
  logic        completion_req;
  completion_t completion_data;
  logic        completion_ack;
  logic        result_req;
  result_t     result_data;
  logic        result_ack;
  logic        full;
  logic        empty;

  // Reference model, stored request per tag plus occupancy
  request_t         model_req [SLOTS];
  logic [SLOTS-1:0] model_valid;
  int               cycle_count = 0;

  ooo_tracker_top dut (
    .clock           ( clock           ),
    .resetn          ( resetn          ),
    .request_req     ( request_req     ),
    .request_data    ( request_data    ),
    .request_ack     ( request_ack     ),
    .request_tag     ( request_tag     ),
    .completion_req  ( completion_req  ),
    .completion_data ( completion_data ),
    .completion_ack  ( completion_ack  ),
    .result_req      ( result_req      ),
    .result_data     ( result_data     ),
    .result_ack      ( result_ack      ),
    .full            ( full            ),
    .empty           ( empty           )
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped");
  endtask

  // Run limit scaled to the transaction count
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("Timeout: run did not finish in %0d cycles", cycle_count));
    end
  end

  task automatic check_tag(input tag_t got, input tag_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t: %s tag %0d, expected %0d",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_result(input result_t got, input result_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t: result %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // Flags as the model says, only between handshakes
  task automatic check_flags();
    check_flag(full, &model_valid, "full");
    check_flag(empty, ~|model_valid, "empty");
  endtask

  // Lowest slot the model holds free
  function automatic tag_t lowest_free();
    tag_t idx;
    idx = '0;
    for (int slot = SLOTS - 1; slot >= 0; slot--) begin
      if (!model_valid[slot]) begin
        idx = tag_t'(slot);
      end
    end
    return idx;
  endfunction

  function automatic tag_t random_outstanding();
    tag_t tag;
    do tag = tag_t'($urandom_range(SLOTS - 1)); while (!model_valid[tag]);
    return tag;
  endfunction

  function automatic logic [`OOO_RESP_W-1:0] random_response();
    logic [31:0] rnd;
    rnd = $urandom();
    return rnd[`OOO_RESP_W-1:0];
  endfunction

  task automatic raise_request(input request_t req);
    @(negedge clock);
    request_data = req;
    request_req  = 1'b1;
  endtask

  // Ack, tag check against the model, then release
  task automatic await_request_ack();
    tag_t exp;
    do @(negedge clock); while (!request_ack);
    exp = lowest_free();
    check_tag(request_tag, exp, "request");
    model_req[exp]   = request_data;
    model_valid[exp] = 1'b1;
    request_req      = 1'b0;
    do @(negedge clock); while (request_ack);
  endtask

  task automatic issue_request(input request_t req);
    raise_request(req);
    await_request_ack();
  endtask

  // Full completion and result handshake with a random result_ack delay
  task automatic complete_tag(input tag_t tag, input logic [`OOO_RESP_W-1:0] resp);
    result_t exp;
    int      delay;
    exp.tag      = tag;
    // Unknown tag comes back with no request
    exp.request  = model_valid[tag] ? model_req[tag] : '0;
    exp.response = resp;
    exp.error    = !model_valid[tag];
    delay        = $urandom_range(3);
    @(negedge clock);
    completion_data.tag      = tag;
    completion_data.response = resp;
    completion_req           = 1'b1;
    do @(negedge clock); while (!result_req);
    check_result(result_data, exp);
    repeat (delay) @(negedge clock);
    result_ack = 1'b1;
    do @(negedge clock); while (result_req);
    result_ack = 1'b0;
    do @(negedge clock); while (!completion_ack);
    completion_req = 1'b0;
    do @(negedge clock); while (completion_ack);
    model_valid[tag] = 1'b0;
  endtask

  initial begin
    tag_t tag;
    void'($urandom(32'h59320263));
    resetn          = 1'b0;
    request_req     = 1'b0;
    request_data    = '0;
    completion_req  = 1'b0;
    completion_data = '0;
    result_ack      = 1'b0;
    model_valid     = '0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    resetn = 1'b1;
    check_flags();

    // Tags handed out lowest free first
    repeat (3) issue_request(request_t'($urandom()));
    check_flags();
    // Completions in random order
    while (model_valid != '0) complete_tag(random_outstanding(), random_response());
    check_flags();

    // Tag not outstanding, error result and no state change
    issue_request(request_t'($urandom()));
    tag = lowest_free();
    complete_tag(tag, random_response());
    check_flags();
    complete_tag(random_outstanding(), random_response());
    check_flags();

    // Fill every slot, the ninth request waits
    repeat (SLOTS) issue_request(request_t'($urandom()));
    check_flags();
    raise_request(request_t'($urandom()));
    repeat (20) begin
      @(negedge clock);
      check_flag(request_ack, 1'b0, "request_ack while full");
    end
    // Freed slot is the only free one, so it must be the tag
    tag = random_outstanding();
    complete_tag(tag, random_response());
    await_request_ack();
    while (model_valid != '0) complete_tag(random_outstanding(), random_response());
    check_flags();

    // Random mix, now and then an arbitrary tag
    for (int op = 0; op < MIX_OPS; op++) begin
      if (model_valid == '0 || (!(&model_valid) && $urandom_range(1) == 0)) begin
        issue_request(request_t'($urandom()));
      end else if ($urandom_range(7) == 0) begin
        complete_tag(tag_t'($urandom_range(SLOTS - 1)), random_response());
      end else begin
        complete_tag(random_outstanding(), random_response());
      end
      check_flags();
    end
    while (model_valid != '0) complete_tag(random_outstanding(), random_response());
    check_flags();

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire
